//--- logic/aluDataPkg.sv
// word-level types shared by every datapath unit
package aluDataPkg;

    localparam int DataWidth = 32; // one MIPS word

    // operands, unit outputs and the registered result all use this
    typedef logic [DataWidth-1:0] dataWord;

endpackage

//--- logic/aluOpPkg.sv
// command encoding and the internal result-source codes
package aluOpPkg;

    localparam int CmdWidth = 3;
    localparam int SelWidth = 3;

    typedef logic [CmdWidth-1:0] aluCmd;
    typedef logic [SelWidth-1:0] resultSel;

    // external command codes, MIPS subset
    localparam aluCmd CmdAdd  = 3'd0;
    localparam aluCmd CmdSub  = 3'd1;
    localparam aluCmd CmdXor  = 3'd2;
    localparam aluCmd CmdSlt  = 3'd3;
    localparam aluCmd CmdAnd  = 3'd4;
    localparam aluCmd CmdNand = 3'd5;
    localparam aluCmd CmdNor  = 3'd6;
    localparam aluCmd CmdOr   = 3'd7;

    // which unit output becomes the result word
    localparam resultSel SelSum  = 3'd0;
    localparam resultSel SelXor  = 3'd1;
    localparam resultSel SelSlt  = 3'd2;
    localparam resultSel SelNand = 3'd3; // also or, with both operands inverted
    localparam resultSel SelNor  = 3'd4; // also and, with both operands inverted

endpackage

//--- logic/aluControlLut.sv
// decodes a command into a result source and the operand-invert controls
module aluControlLut import aluOpPkg::*; (
    input  aluCmd    command,
    output resultSel sel,
    output logic     invA,
    output logic     invB
);

    always_comb begin
        // add is the fallback for anything unlisted
        sel  = SelSum;
        invA = 1'b0;
        invB = 1'b0;
        case (command)
            CmdAdd: begin
                sel = SelSum;
            end
            CmdSub: begin
                sel  = SelSum;
                invB = 1'b1; // a + ~b + 1
            end
            CmdXor: begin
                sel = SelXor;
            end
            CmdSlt: begin
                sel  = SelSlt;
                invB = 1'b1; // slt reads the sign of a - b
            end
            CmdAnd: begin
                sel  = SelNor; // ~(~a | ~b) = a & b
                invA = 1'b1;
                invB = 1'b1;
            end
            CmdNand: begin
                sel = SelNand;
            end
            CmdNor: begin
                sel = SelNor;
            end
            CmdOr: begin
                sel  = SelNand; // ~(~a & ~b) = a | b
                invA = 1'b1;
                invB = 1'b1;
            end
            default: begin
                sel = SelSum;
            end
        endcase
    end

endmodule

//--- logic/rippleAdder.sv
// 32-stage ripple-carry adder, subtracts when invB is set
module rippleAdder import aluDataPkg::*; (
    input  dataWord a,
    input  dataWord b,
    input  logic    invB,
    output dataWord sum,
    output logic    adderCarry,
    output logic    adderOverflow
);

    dataWord              bEff;  // b after the optional invert
    logic [DataWidth:0]   carry; // carry[i] enters bit i

    assign bEff     = invB ? ~b : b;
    assign carry[0] = invB;      // the +1 of two's complement negation

    // one full adder per bit, carry rippling upward
    for (genvar i = 0; i < DataWidth; i++) begin : gStage
        logic halfSum;

        assign halfSum      = a[i] ^ bEff[i];
        assign sum[i]       = halfSum ^ carry[i];
        assign carry[i + 1] = (a[i] & bEff[i]) | (halfSum & carry[i]);
    end

    assign adderCarry = carry[DataWidth];

    // signed overflow when the carry into the sign bit differs from the one out
    assign adderOverflow = carry[DataWidth - 1] ^ carry[DataWidth];

endmodule

//--- logic/logicUnit.sv
// bitwise xor, nand and nor of the conditionally inverted operands
module logicUnit import aluDataPkg::*; (
    input  dataWord a,
    input  dataWord b,
    input  logic    invA,
    input  logic    invB,
    output dataWord xorOut,
    output dataWord nandOut,
    output dataWord norOut
);

    dataWord aEff;
    dataWord bEff;

    assign aEff = invA ? ~a : a;
    assign bEff = invB ? ~b : b;

    assign xorOut = aEff ^ bEff;

    // with both inputs inverted nand gives or
    assign nandOut = ~(aEff & bEff);

    // and nor gives and
    assign norOut = ~(aEff | bEff);

endmodule

//--- logic/aluResultStage.sv
// result mux, slt, flag gating, zero detect and the output register
module aluResultStage import aluDataPkg::*, aluOpPkg::*; (
    input  logic     clk,
    input  logic     rstN,
    input  logic     opValid,
    input  resultSel sel,
    input  dataWord  sum,
    input  dataWord  xorOut,
    input  dataWord  nandOut,
    input  dataWord  norOut,
    input  logic     adderCarry,
    input  logic     adderOverflow,
    output dataWord  result,
    output logic     carryOut,
    output logic     overflow,
    output logic     zero,
    output logic     resultValid
);

    dataWord sltWord;
    dataWord selWord;
    logic    isSum;
    logic    carryNext;
    logic    overflowNext;
    logic    zeroNext;

    // a < b when the sign of a - b is set, corrected by overflow
    assign sltWord = {{(DataWidth - 1){1'b0}}, sum[DataWidth - 1] ^ adderOverflow};

    always_comb begin
        case (sel)
            SelSum:  selWord = sum;
            SelXor:  selWord = xorOut;
            SelSlt:  selWord = sltWord;
            SelNand: selWord = nandOut;
            SelNor:  selWord = norOut;
            default: selWord = '0; // unused codes
        endcase
    end

    // flags only mean something for add and sub
    assign isSum        = (sel == SelSum);
    assign carryNext    = adderCarry & isSum;
    assign overflowNext = adderOverflow & isSum;

    assign zeroNext = (selWord == '0);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            result      <= '0;
            carryOut    <= 1'b0;
            overflow    <= 1'b0;
            zero        <= 1'b0;
            resultValid <= 1'b0;
        end else begin
            resultValid <= opValid; // one-cycle strobe per sampled op
            if (opValid) begin
                result   <= selWord;
                carryOut <= carryNext;
                overflow <= overflowNext;
                zero     <= zeroNext;
            end
        end
    end

endmodule

//--- logic/aluTop.sv
// 32-bit MIPS-subset ALU with one registered output stage
module aluTop import aluDataPkg::*, aluOpPkg::*; (
    input  logic    clk,
    input  logic    rstN,
    input  logic    opValid,
    input  dataWord operandA,
    input  dataWord operandB,
    input  aluCmd   command,
    output dataWord result,
    output logic    carryOut,
    output logic    overflow,
    output logic    zero,
    output logic    resultValid
);

    // decode controls
    resultSel sel;
    logic     invA;
    logic     invB;

    // unit outputs, all combinational
    dataWord  sum;
    dataWord  xorOut;
    dataWord  nandOut;
    dataWord  norOut;
    logic     adderCarry;
    logic     adderOverflow;

    aluControlLut lut0 (
        .command (command),
        .sel     (sel),
        .invA    (invA),
        .invB    (invB)
    );

    // invA is never set for the adder commands, so only b is inverted here
    rippleAdder adder0 (
        .a             (operandA),
        .b             (operandB),
        .invB          (invB),
        .sum           (sum),
        .adderCarry    (adderCarry),
        .adderOverflow (adderOverflow)
    );

    logicUnit logic0 (
        .a       (operandA),
        .b       (operandB),
        .invA    (invA),
        .invB    (invB),
        .xorOut  (xorOut),
        .nandOut (nandOut),
        .norOut  (norOut)
    );

    aluResultStage stage0 (
        .clk           (clk),
        .rstN          (rstN),
        .opValid       (opValid),
        .sel           (sel),
        .sum           (sum),
        .xorOut        (xorOut),
        .nandOut       (nandOut),
        .norOut        (norOut),
        .adderCarry    (adderCarry),
        .adderOverflow (adderOverflow),
        .result        (result),
        .carryOut      (carryOut),
        .overflow      (overflow),
        .zero          (zero),
        .resultValid   (resultValid)
    );

endmodule

//--- test/aluTop_sva.sv
// concurrent checks on the ALU output register
module aluTopSva import aluDataPkg::*; (
    input logic    clk,
    input logic    rstN,
    input logic    opValid,
    input dataWord result,
    input logic    carryOut,
    input logic    overflow,
    input logic    zero,
    input logic    resultValid
);

    timeunit 1ns;
    timeprecision 1ps;

    // the strobe follows opValid by exactly one edge
    validFollowsOp: assert property (
        @(posedge clk) $past(rstN) |-> resultValid == $past(opValid)
    ) else $error("resultValid does not follow opValid by one cycle");

    // a reset edge clears every output
    resetClears: assert property (
        @(posedge clk) !rstN |=> (result == '0) && !carryOut && !overflow &&
                                 !zero && !resultValid
    ) else $error("outputs not cleared after reset");

    zeroMatchesResult: assert property (
        @(posedge clk) resultValid |-> zero == (result == '0)
    ) else $error("zero flag disagrees with result");

    // no new operation, so the last answer stays
    holdOnIdle: assert property (
        @(posedge clk) $fell(resultValid) && $past(rstN) |-> $stable(result) && $stable(zero)
    ) else $error("result changed while no operation was sampled");

endmodule

bind aluTop aluTopSva sva0 (.*);

//--- test/aluTb.sv
// testbench for the registered 32-bit ALU
module aluTb import aluDataPkg::*, aluOpPkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int ClkPeriod   = 20;
    localparam int ResetCycles = 8;
    localparam int Seed        = 8;
    localparam int NumCorners  = 9;
    localparam int NumRandom   = 240;

    // every cycle the stimulus can spend after reset, idle ones included
    localparam int NumSlots = 2 + NumCorners * 8 + 8 + NumRandom + NumRandom / 4 + 5;
    localparam int WatchdogCycles = ResetCycles + NumSlots + 20;

    // what the model says an operation should produce
    typedef struct packed {
        dataWord value;
        logic    carry;
        logic    ovf;
        logic    isZero;
    } opResult;

    logic    clk;
    logic    rstN;
    logic    opValid;
    dataWord operandA;
    dataWord operandB;
    aluCmd   command;
    dataWord result;
    logic    carryOut;
    logic    overflow;
    logic    zero;
    logic    resultValid;

    opResult expectQ[$]; // one entry per sampled operation, oldest first

    aluTop dut0 (
        .clk         (clk),
        .rstN        (rstN),
        .opValid     (opValid),
        .operandA    (operandA),
        .operandB    (operandB),
        .command     (command),
        .result      (result),
        .carryOut    (carryOut),
        .overflow    (overflow),
        .zero        (zero),
        .resultValid (resultValid)
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    // expected outputs from the arithmetic definition of each command
    function automatic opResult aluModel(input dataWord a, input dataWord b, input aluCmd cmd);
        opResult            r;
        logic [DataWidth:0] wide;
        r    = '0;
        wide = '0;
        case (cmd)
            CmdAdd: begin
                wide    = {1'b0, a} + {1'b0, b};
                r.value = wide[DataWidth-1:0];
                r.carry = wide[DataWidth];
                // same signs in, different sign out
                r.ovf   = (a[DataWidth-1] == b[DataWidth-1]) &&
                          (r.value[DataWidth-1] != a[DataWidth-1]);
            end
            CmdSub: begin
                wide    = {1'b0, a} + {1'b0, ~b} + 1;
                r.value = wide[DataWidth-1:0];
                r.carry = wide[DataWidth]; // 1 means no borrow
                r.ovf   = (a[DataWidth-1] != b[DataWidth-1]) &&
                          (r.value[DataWidth-1] != a[DataWidth-1]);
            end
            CmdXor:  r.value = a ^ b;
            CmdSlt:  r.value = ($signed(a) < $signed(b)) ? dataWord'(1) : '0;
            CmdAnd:  r.value = a & b;
            CmdNand: r.value = ~(a & b);
            CmdNor:  r.value = ~(a | b);
            CmdOr:   r.value = a | b;
            default: r.value = '0;
        endcase
        r.isZero = (r.value == '0);
        return r;
    endfunction

    task automatic failRun(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkValue(input string name, input dataWord actual, input dataWord wanted);
        if (actual !== wanted) begin
            failRun($sformatf("mismatch at %0t ns: %s is %h, expected %h",
                              $time, name, actual, wanted));
        end
    endtask

    task automatic checkOutputs(input opResult want);
        checkValue("result", result, want.value);
        checkValue("carryOut", dataWord'(carryOut), dataWord'(want.carry));
        checkValue("overflow", dataWord'(overflow), dataWord'(want.ovf));
        checkValue("zero", dataWord'(zero), dataWord'(want.isZero));
    endtask

    // directed operand pairs
    task automatic cornerOperands(input int idx, output dataWord a, output dataWord b);
        case (idx)
            0: {a, b} = {32'h0000_0000, 32'h0000_0000};
            1: {a, b} = {32'hFFFF_FFFF, 32'hFFFF_FFFF};
            2: {a, b} = {32'h8000_0000, 32'h0000_0001}; // most negative, minus one
            3: {a, b} = {32'h7FFF_FFFF, 32'h7FFF_FFFF}; // large positives
            4: {a, b} = {32'h1234_5678, 32'h1234_5678}; // equal operands
            5: {a, b} = {32'hFFFF_FFFF, 32'h0000_0000};
            6: {a, b} = {32'h0F0F_0F0F, 32'hF0F0_F0F0}; // disjoint bits
            7: {a, b} = {32'h8000_0000, 32'h7FFF_FFFF}; // slt with overflow
            default: {a, b} = {32'h7FFF_FFFF, 32'h8000_0000};
        endcase
    endtask

    task automatic issueOp(input dataWord a, input dataWord b, input aluCmd cmd);
        @(negedge clk);
        opValid  = 1'b1;
        operandA = a;
        operandB = b;
        command  = cmd;
    endtask

    // inputs keep moving while idle, outputs must not
    task automatic idleCycle();
        @(negedge clk);
        opValid  = 1'b0;
        operandA = $urandom();
        operandB = $urandom();
        command  = aluCmd'($urandom_range(7, 0));
    endtask

    // record each operation the DUT samples
    always @(posedge clk) begin
        if (rstN && opValid) begin
            expectQ.push_back(aluModel(operandA, operandB, command));
        end
    end

    initial begin : compareOutputs
        opResult got;
        opResult lastAnswer;
        lastAnswer = '0; // reset value of every output
        @(posedge clk);
        forever begin
            @(negedge clk);
            if (resultValid) begin
                if (expectQ.size() == 0) begin
                    failRun("resultValid is high but no operation was sampled");
                end
                got        = expectQ.pop_front();
                lastAnswer = got;
                checkOutputs(got);
            end else begin
                if (expectQ.size() != 0) begin
                    failRun("a sampled operation got no answer one cycle later");
                end
                checkOutputs(lastAnswer); // holds the previous answer
            end
        end
    end

    initial begin : watchdog
        #(WatchdogCycles * ClkPeriod);
        failRun("timeout: the run did not finish in time");
    end

    initial begin : stimulus
        dataWord a;
        dataWord b;
        void'($urandom(Seed));
        rstN     = 1'b0;
        opValid  = 1'b0;
        operandA = '0;
        operandB = '0;
        command  = CmdAdd;
        repeat (ResetCycles) @(negedge clk);
        rstN = 1'b1;
        idleCycle();
        idleCycle();

        // every command over every corner pair, then a pause
        for (int c = 0; c < 8; c++) begin
            for (int i = 0; i < NumCorners; i++) begin
                cornerOperands(i, a, b);
                issueOp(a, b, aluCmd'(c));
            end
            idleCycle();
        end

        // random back-to-back operations with a gap after every fourth
        for (int i = 0; i < NumRandom; i++) begin
            a = $urandom();
            b = $urandom();
            issueOp(a, b, aluCmd'($urandom_range(7, 0)));
            if (i % 4 == 3) begin
                idleCycle();
            end
        end

        idleCycle();
        while (expectQ.size() != 0) begin
            @(negedge clk);
        end
        repeat (4) idleCycle();

        $display("Done: no errors");
        $finish;
    end

endmodule

//--- filelist.f
logic/aluDataPkg.sv
logic/aluOpPkg.sv
logic/aluControlLut.sv
logic/rippleAdder.sv
logic/logicUnit.sv
logic/aluResultStage.sv
logic/aluTop.sv
test/aluTop_sva.sv
test/aluTb.sv

//--- Bender.yml
package:
  name: mips_alu

sources:
  # packages first, then the datapath units and the top level
  - files:
      - logic/aluDataPkg.sv
      - logic/aluOpPkg.sv
      - logic/aluControlLut.sv
      - logic/rippleAdder.sv
      - logic/logicUnit.sv
      - logic/aluResultStage.sv
      - logic/aluTop.sv

  # testbench and bound assertions
  - target: test
    files:
      - test/aluTop_sva.sv
      - test/aluTb.sv
